// ==== all.f ====
src/core_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_control.sv
src/execute_stage.sv
src/hazard_unit.sv
src/riscv_pipeline_core.sv
sim/tb_clock_gen.sv
sim/core_chk.sv
sim/tb_core.sv

// ==== sim/core_chk.sv ====
`timescale 1ns/100ps

module core_chk import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input logic      clk,
    input logic      reset,
    input word_t     imem_addr,
    input dmem_req_t dmem_req
);

    localparam word_t poison_addr = 32'h0000_03f0;
    localparam word_t done_addr   = 32'h0000_03fc;

    int           error_count = 0;
    logic         reset_seen = 1'b0;
    logic [255:0] stored;
    logic         all_stored;

    // Bit 32 marks an address the program stores to
    function automatic logic [32:0] expected_store(input word_t addr);
        case (addr)
            32'h0000_0100: return {1'b1, 32'h1234_5578};
            32'h0000_0104: return {1'b1, 32'h1234_5778};
            32'h0000_0108: return {1'b1, 32'h1234_5600};
            32'h0000_010c: return {1'b1, 32'hffff_ff78};
            32'h0000_0110: return {1'b1, 32'hedcb_a978};
            32'h0000_0114: return {1'b1, 32'h0000_0001};
            32'h0000_0118: return {1'b1, 32'h468a_cf00};
            32'h0000_011c: return {1'b1, 32'h07ff_fff8};
            32'h0000_0120: return {1'b1, 32'h1234_5677};
            32'h0000_0124: return {1'b1, 32'h0000_0070};
            32'h0000_0128: return {1'b1, 32'hffff_ff78};
            32'h0000_012c: return {1'b1, 32'h1234_5187};
            32'h0000_0130: return {1'b1, 32'h0000_0001};
            // Forwarded chain and the same chain spaced out
            32'h0000_0140: return {1'b1, 32'h0000_00c0};
            32'h0000_0144: return {1'b1, 32'h0000_0003};
            32'h0000_0148: return {1'b1, 32'h0000_00c0};
            32'h0000_014c: return {1'b1, 32'h0000_0003};
            32'h0000_0150: return {1'b1, 32'h1234_5688};
            32'h0000_0154: return {1'b1, 32'h0000_0000};
            32'h0000_0158: return {1'b1, 32'h0000_0006};
            32'h0000_03fc: return {1'b1, 32'h0000_0005};
            default:       return '0;
        endcase
    endfunction

    function automatic logic store_known(input word_t addr);
        logic [32:0] entry;
        entry = expected_store(addr);
        return entry[32];
    endfunction

    function automatic word_t store_value(input word_t addr);
        logic [32:0] entry;
        entry = expected_store(addr);
        return entry[31:0];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            reset_seen <= 1'b1;
            stored     <= '0;
        end else if (dmem_req.write) begin
            stored[dmem_req.addr[9:2]] <= 1'b1;
        end
    end

    // Every result store other than the done store seen
    always_comb begin
        all_stored = 1'b1;
        for (int i = 0; i < 256; i++) begin
            if (store_known(word_t'(i * 4)) && word_t'(i * 4) != done_addr && !stored[i]) begin
                all_stored = 1'b0;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        reset && reset_seen |-> !dmem_req.write && !dmem_req.read)
        else begin
            error_count++;
            $error("error dmem_req.write %h dmem_req.read %h while reset is high",
                   $sampled(dmem_req.write), $sampled(dmem_req.read));
        end

    start_address: assert property (@(posedge clk) $fell(reset) |-> imem_addr == reset_pc)
        else begin
            error_count++;
            $error("error imem_addr %h expected %h", $sampled(imem_addr), reset_pc);
        end

    no_squashed_store: assert property (@(posedge clk)
        !reset && dmem_req.write |-> dmem_req.addr != poison_addr)
        else begin
            error_count++;
            $error("error dmem_req.addr %h written by an instruction after a taken branch",
                   $sampled(dmem_req.addr));
        end

    store_data: assert property (@(posedge clk)
        !reset && dmem_req.write && dmem_req.addr != poison_addr |->
        store_known(dmem_req.addr) && dmem_req.wdata == store_value(dmem_req.addr))
        else begin
            error_count++;
            $error("error dmem_req.wdata %h expected %h at dmem_req.addr %h",
                   $sampled(dmem_req.wdata), store_value($sampled(dmem_req.addr)),
                   $sampled(dmem_req.addr));
        end

    stores_before_done: assert property (@(posedge clk)
        !reset && dmem_req.write && dmem_req.addr == done_addr |-> all_stored)
        else begin
            error_count++;
            $error("error done store reached while some result stores never happened");
        end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Released on a rising edge like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== sim/tb_core.sv ====
`timescale 1ns/100ps

module tb_core import core_pkg::*; ();

    localparam word_t reset_pc    = 32'h0000_0200;
    localparam word_t poison_addr = 32'h0000_03f0;
    localparam word_t done_addr   = 32'h0000_03fc;
    // Program finishes in under 100 cycles with reset
    localparam int    max_cycles  = 400;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;
    localparam word_t      nop     = 32'h0000_0013;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    word_t     rom_offset;
    word_t     rom [128];
    word_t     ram [256];
    int        rom_len;
    int        cycles;
    logic      done_seen;
    logic      timed_out;

    tb_clock_gen i_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    riscv_pipeline_core #(
        .reset_pc (reset_pc)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    bind riscv_pipeline_core core_chk #(
        .reset_pc (reset_pc)
    ) i_chk (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .dmem_req  (dmem_req)
    );

    // Program ROM and data RAM read combinationally
    assign rom_offset = imem_addr - reset_pc;
    assign imem_data  = rom[rom_offset[8:2]];
    // Data comes back only for a read request
    assign dmem_rdata = dmem_req.read ? ram[dmem_req.addr[9:2]] : '0;

    always @(posedge clk) begin
        if (dmem_req.write) begin
            ram[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_rtype};
    endfunction

    function automatic word_t i_type(input opcode_e opc, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic word_t s_word(input int rs2, input int rs1, input int imm);
        logic [11:0] imm12;
        imm12 = 12'(imm);
        return {imm12[11:5], 5'(rs2), 5'(rs1), f3_word, imm12[4:0], op_store};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int offset);
        logic [12:0] off;
        off = 13'(offset);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], op_branch};
    endfunction

    task automatic emit(input word_t instr);
        rom[rom_len] = instr;
        rom_len++;
    endtask

    task automatic pad(input int count);
        repeat (count) emit(nop);
    endtask

    task automatic load_program();
        foreach (rom[i]) begin
            rom[i] = nop;
        end
        rom_len = 0;
        emit(i_type(op_load, f3_word, 1, 0, 0));
        emit(i_type(op_load, f3_word, 2, 0, 4));
        emit(i_type(op_itype, f3_add, 3, 0, 5));
        emit(r_type(f7_base, f3_add, 4, 1, 2));
        emit(r_type(f7_sub, f3_add, 5, 1, 2));
        emit(r_type(f7_base, f3_and, 6, 1, 2));
        emit(r_type(f7_base, f3_or, 7, 1, 2));
        emit(r_type(f7_base, f3_xor, 8, 1, 2));
        emit(r_type(f7_base, f3_slt, 9, 2, 1));
        emit(r_type(f7_base, f3_sll, 10, 1, 3));
        emit(r_type(f7_base, f3_srl, 11, 2, 3));
        for (int r = 4; r <= 11; r++) begin
            emit(s_word(r, 0, 'h100 + 4 * (r - 4)));
        end
        emit(i_type(op_itype, f3_add, 12, 1, -1));
        emit(i_type(op_itype, f3_and, 13, 1, 'h0f0));
        emit(i_type(op_itype, f3_or, 14, 1, -256));
        emit(i_type(op_itype, f3_xor, 15, 1, 'h7ff));
        emit(i_type(op_itype, f3_slt, 16, 2, -255));
        for (int r = 12; r <= 16; r++) begin
            emit(s_word(r, 0, 'h120 + 4 * (r - 12)));
        end
        // Chain at distances one and two
        emit(i_type(op_itype, f3_add, 17, 0, 3));
        emit(r_type(f7_base, f3_add, 18, 17, 17));
        emit(r_type(f7_sub, f3_add, 19, 18, 17));
        emit(r_type(f7_base, f3_sll, 20, 19, 18));
        emit(s_word(20, 0, 'h140));
        emit(s_word(19, 0, 'h144));
        // Same chain spaced past the forwarding window
        emit(i_type(op_itype, f3_add, 21, 0, 3));
        pad(3);
        emit(r_type(f7_base, f3_add, 22, 21, 21));
        pad(3);
        emit(r_type(f7_sub, f3_add, 23, 22, 21));
        pad(3);
        emit(r_type(f7_base, f3_sll, 24, 23, 22));
        pad(3);
        emit(s_word(24, 0, 'h148));
        emit(s_word(23, 0, 'h14c));
        // Load-use pair and then writes to x0
        emit(i_type(op_load, f3_word, 25, 0, 0));
        emit(i_type(op_itype, f3_add, 26, 25, 'h10));
        emit(s_word(26, 0, 'h150));
        emit(i_type(op_itype, f3_add, 0, 1, 'h55));
        emit(s_word(0, 0, 'h154));
        // Taken beq, taken bne, then a not-taken beq
        emit(b_type(f3_beq, 17, 21, 12));
        emit(s_word(1, 0, poison_addr));
        emit(s_word(1, 0, poison_addr));
        emit(b_type(f3_bne, 17, 18, 12));
        emit(s_word(1, 0, poison_addr));
        emit(s_word(1, 0, poison_addr));
        emit(b_type(f3_beq, 17, 18, 8));
        emit(s_word(18, 0, 'h158));
        emit(s_word(3, 0, done_addr));
    endtask

    task automatic init_ram();
        foreach (ram[i]) begin
            ram[i] = 32'hc0de_0000 ^ word_t'(i * 4);
        end
        ram[0] = 32'h1234_5678;
        ram[1] = 32'hffff_ff00;
    endtask

    initial begin
        load_program();
        init_ram();
        cycles    = 0;
        done_seen = 1'b0;
        timed_out = 1'b0;
        while (!done_seen && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (!reset && dmem_req.write && dmem_req.addr == done_addr) begin
                done_seen = 1'b1;
            end else if (cycles >= max_cycles) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("Run stopped after %0d cycles, the program never reached its done store",
                     cycles);
        end else begin
            // Done store still has to pass its checks
            repeat (2) @(posedge clk);
        end
        $display("Errors: %0d assertion failures, %0d timeouts",
                 i_dut.i_chk.error_count, timed_out);
        if (i_dut.i_chk.error_count == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

    // Data width fixed by the RV32 base ISA
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic [2:0] funct3;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t rd;
    } mem_wb_t;

    // Data port request, sampled by the memory on the rising edge
    typedef struct packed {
        logic  write;
        logic  read;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// ==== src/decode_control.sv ====
`timescale 1ns/100ps

module decode_control import core_pkg::*; (
    input  word_t      instr,
    output ctrl_t      ctrl,
    output word_t      imm,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output reg_addr_t  rd,
    output logic [2:0] funct3
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    // ALU controller, sub only reachable from register-register ops
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b101:  return alu_srl;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    // Main controller
    always_comb begin
        ctrl = '0;
        case (opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = funct_to_alu(instr[14:12], instr[30]);
            end
            op_itype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = funct_to_alu(instr[14:12], 1'b0);
            end
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = alu_add;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            op_branch: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
            end
            default: ctrl = '0;
        endcase
    end

    // Immediate generator
    always_comb begin
        case (opcode)
            op_itype, op_load: imm = {{20{instr[31]}}, instr[31:20]};
            op_store:          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default:           imm = '0;
        endcase
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import core_pkg::*; (
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    mem_result,
    input  word_t    wb_result,
    output word_t    alu_result,
    output word_t    store_data,
    output logic     branch_taken,
    output word_t    branch_target
);

    localparam logic [2:0] funct3_beq = 3'b000;
    localparam logic [2:0] funct3_bne = 3'b001;

    word_t op_a;
    word_t op_b;
    word_t alu_in_b;
    logic  zero;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_value);
        case (sel)
            fwd_mem: return mem_result;
            fwd_wb:  return wb_result;
            default: return reg_value;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, id_ex.rs1_data);
    assign op_b = fwd_mux(fwd_b, id_ex.rs2_data);

    // Stores write the forwarded rs2, not the immediate
    assign store_data = op_b;
    assign alu_in_b   = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: alu_result = op_a + alu_in_b;
            alu_sub: alu_result = op_a - alu_in_b;
            alu_and: alu_result = op_a & alu_in_b;
            alu_or:  alu_result = op_a | alu_in_b;
            alu_xor: alu_result = op_a ^ alu_in_b;
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_in_b)};
            end
            alu_sll: alu_result = op_a << alu_in_b[4:0];
            alu_srl: alu_result = op_a >> alu_in_b[4:0];
            default: alu_result = op_a + alu_in_b;
        endcase
    end

    assign zero = (alu_result == '0);

    // Branch decision on the subtract result
    always_comb begin
        branch_taken = 1'b0;
        if (id_ex.ctrl.branch) begin
            case (id_ex.funct3)
                funct3_beq: branch_taken = zero;
                funct3_bne: branch_taken = !zero;
                default:    branch_taken = 1'b0;
            endcase
        end
    end

    assign branch_target = id_ex.pc + id_ex.imm;

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t id_pc,
    output word_t id_instr
);

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    word_t pc;
    word_t pc_plus4;
    word_t pc_next;

    assign pc_plus4  = pc + 32'd4;
    assign imem_addr = pc;

    // Taken branch wins, a stall holds the current address
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // Fetch-to-decode register
    always_ff @(posedge clk) begin
        if (reset || branch_taken) begin
            id_instr <= nop_instr;
        end else if (!stall) begin
            id_instr <= imem_data;
        end
        if (!stall) begin
            id_pc <= pc;
        end
    end

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit import core_pkg::*; (
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  id_ex_t    id_ex,
    input  ex_mem_t   ex_mem,
    input  mem_wb_t   mem_wb,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    logic load_in_ex;

    // Load in execute whose result decode needs next cycle
    assign load_in_ex = id_ex.ctrl.mem_read && id_ex.rd != 5'd0;
    assign stall = load_in_ex && (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

    // Youngest producer wins
    function automatic fwd_sel_e fwd_select(input reg_addr_t rs);
        if (rs == 5'd0) begin
            return fwd_none;
        end else if (ex_mem.ctrl.reg_write && ex_mem.rd == rs) begin
            return fwd_mem;
        end else if (mem_wb.reg_write && mem_wb.rd == rs) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a = fwd_select(id_ex.rs1);
    assign fwd_b = fwd_select(id_ex.rs2);

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/100ps

module register_file import core_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      rd_write,
    input  word_t     rd_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rd_write && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (rd_write && rd == addr) begin
            return rd_data;
        end
        return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

endmodule

// ==== src/riscv_pipeline_core.sv ====
`timescale 1ns/100ps

module riscv_pipeline_core import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    // Decode stage
    word_t      id_pc;
    word_t      id_instr;
    ctrl_t      id_ctrl;
    word_t      id_imm;
    reg_addr_t  id_rs1;
    reg_addr_t  id_rs2;
    reg_addr_t  id_rd;
    logic [2:0] id_funct3;
    word_t      rs1_data;
    word_t      rs2_data;

    // Stage registers
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // Execute stage and hazards
    logic     stall;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    alu_result;
    word_t    store_data;
    logic     branch_taken;
    word_t    branch_target;
    word_t    wb_result;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .id_pc         (id_pc),
        .id_instr      (id_instr)
    );

    decode_control i_decode (
        .instr  (id_instr),
        .ctrl   (id_ctrl),
        .imm    (id_imm),
        .rs1    (id_rs1),
        .rs2    (id_rs2),
        .rd     (id_rd),
        .funct3 (id_funct3)
    );

    register_file i_regs (
        .clk      (clk),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rd       (mem_wb.rd),
        .rd_write (mem_wb.reg_write),
        .rd_data  (wb_result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    hazard_unit i_hazard (
        .id_rs1 (id_rs1),
        .id_rs2 (id_rs2),
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .stall  (stall),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage i_execute (
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_result    (ex_mem.alu_result),
        .wb_result     (wb_result),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // Decode to execute, a stall or taken branch inserts a bubble
    always_ff @(posedge clk) begin
        id_ex <= '{ctrl: id_ctrl, pc: id_pc, rs1_data: rs1_data, rs2_data: rs2_data,
                   imm: id_imm, rs1: id_rs1, rs2: id_rs2, rd: id_rd, funct3: id_funct3};
        if (reset || stall || branch_taken) begin
            id_ex.ctrl <= '0;
        end
    end

    // Execute to memory
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= store_data;
        ex_mem.rd         <= id_ex.rd;
    end

    assign dmem_req = '{write: ex_mem.ctrl.mem_write, read: ex_mem.ctrl.mem_read,
                        addr: ex_mem.alu_result, wdata: ex_mem.store_data};

    // Memory to write-back
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
        end
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= dmem_rdata;
        mem_wb.rd         <= ex_mem.rd;
    end

    assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule
